// ==== design/decode_consts.svh ====
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Data bus and instruction register width
`define DATA_W 8

// Register file select, B C D E H L (HL) A
`define REG_SEL_W 3

// 16-bit address source select
// PC=000 BC=100 DE=101 HL=110
`define ADDR_SEL_W 3

// M-cycle counter width
// Longest kept instruction is LD rr,nn with 3 M-cycles
`define M_CNT_W 2

// Opcode held after reset, decodes as a one M-cycle NOP
`define NOP_OPCODE 8'h00

`endif

// ==== design/cpu_decode_pkg.sv ====
`default_nettype none

`include "decode_consts.svh"

package cpu_decode_pkg;

    typedef enum logic [1:0] {T1, T2, T3, T4} t_phase_e;

    typedef enum logic [`REG_SEL_W-1:0] {
        B = 3'd0, C = 3'd1, D = 3'd2, E = 3'd3,
        H = 3'd4, L = 3'd5, MEM_HL = 3'd6, A = 3'd7
    } reg_sel_e;

    // Same order as opcode bits 5..3
    typedef enum logic [2:0] {ADD, ADC, SUB, SBC, AND, XOR, OR, CP} alu_op_e;

    typedef enum logic [1:0] {SBUS = 2'd0, ALU = 2'd1, MEM = 2'd2} dbus_src_e;

    typedef enum logic [`ADDR_SEL_W-1:0] {
        PC = 3'b000, BC = 3'b100, DE = 3'b101, HL = 3'b110
    } addr_src_e;

    typedef enum logic [3:0] {
        OP_NOP, OP_LD_RR, OP_LD_R_HL, OP_LD_HL_R, OP_LD_R_N, OP_ALU_R,
        OP_ALU_HL, OP_ALU_N, OP_INC_R, OP_DEC_R, OP_LD_RR_NN
    } op_class_e;

    typedef struct packed {
        logic [`M_CNT_W-1:0] m_cycle;
        t_phase_e            t_phase;
        logic                last_m;   // Final M-cycle of the instruction
    } cycle_t;

    // What one M-cycle wants, before T-phase gating
    typedef struct packed {
        logic      mem_rd;
        logic      mem_wr;
        addr_src_e addr_sel;
        logic      reg_rd_en;
        reg_sel_e  reg_rd_addr;
        logic      reg_wr;
        reg_sel_e  reg_wr_addr;
        dbus_src_e src_sel;
        logic      alu_go;
        alu_op_e   alu_op;
        logic      alu_mem_src;  // Operand from memory bus
        logic      alu_incdec;
    } step_t;

    typedef struct packed {
        logic      rd_en;
        reg_sel_e  rd_addr;
        logic      wr_en;
        reg_sel_e  wr_addr;
        dbus_src_e src_sel;
    } reg_ctrl_t;

    typedef struct packed {
        logic    start;
        alu_op_e op;
        logic    mem_src;
        logic    incdec;
    } alu_ctrl_t;

    typedef struct packed {
        logic      rd;
        logic      wr;
        addr_src_e addr_sel;
    } mem_ctrl_t;

endpackage

`default_nettype wire

// ==== design/ir_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

// Instruction register
// The opcode fetched in the final M-cycle becomes current at the next M1 T1
module ir_fetch (
    input  logic               clk,
    input  logic               rst,
    input  logic [`DATA_W-1:0] data_bus_in,
    input  logic               end_of_instr,
    output logic [`DATA_W-1:0] opcode
);

    logic [`DATA_W-1:0] ir_q;

    // Operand bytes read in earlier M-cycles pass by untouched
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ir_q <= `NOP_OPCODE;
        end else if (end_of_instr) begin
            ir_q <= data_bus_in;  // Byte read in final T3, still on the bus
        end
    end

    assign opcode = ir_q;

endmodule

`default_nettype wire

// ==== design/cycle_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module cycle_timer import cpu_decode_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [`M_CNT_W-1:0] m_count,
    output cycle_t              cycle,
    output logic                end_of_instr
);

    logic [`M_CNT_W-1:0] m_q;
    t_phase_e            t_q;
    logic [`M_CNT_W-1:0] last_idx;
    logic                last_m;

    assign last_idx = m_count - `M_CNT_W'(1);  // Index of the final M-cycle
    assign last_m   = (m_q == last_idx);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            m_q <= '0;
            t_q <= T1;
        end else if (t_q == T4) begin
            t_q <= T1;
            // Wrap to M1 once the instruction is done
            m_q <= last_m ? '0 : m_q + `M_CNT_W'(1);
        end else begin
            t_q <= t_phase_e'(t_q + 2'd1);
        end
    end

    assign cycle.m_cycle = m_q;
    assign cycle.t_phase = t_q;
    assign cycle.last_m  = last_m;
    assign end_of_instr  = last_m && (t_q == T4);  // Opcode latch point

endmodule

`default_nettype wire

// ==== design/op_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module op_decoder import cpu_decode_pkg::*; (
    input  logic [`DATA_W-1:0]  opcode,
    input  cycle_t              cycle,
    output logic [`M_CNT_W-1:0] m_count,
    output step_t               step
);

    logic [1:0] prefix;
    logic [2:0] dst_f;
    logic [2:0] src_f;
    op_class_e  op_class;
    reg_sel_e   pair_lo;
    reg_sel_e   pair_hi;
    logic       first_m;

    assign prefix  = opcode[7:6];
    assign dst_f   = opcode[5:3];
    assign src_f   = opcode[2:0];
    assign pair_lo = reg_sel_e'({opcode[5:4], 1'b1});  // C, E or L
    assign pair_hi = reg_sel_e'({opcode[5:4], 1'b0});  // B, D or H
    assign first_m = (cycle.m_cycle == '0);

    always_comb begin
        op_class = OP_NOP;  // Anything unsupported
        case (prefix)
            2'b00: begin
                if (src_f == 3'b001 && !opcode[3] && opcode[5:4] != 2'b11)
                    op_class = OP_LD_RR_NN;
                else if (src_f == 3'b100 && dst_f != 3'b110)
                    op_class = OP_INC_R;
                else if (src_f == 3'b101 && dst_f != 3'b110)
                    op_class = OP_DEC_R;
                else if (src_f == 3'b110 && dst_f != 3'b110)
                    op_class = OP_LD_R_N;
            end
            2'b01: begin
                // 0x76 is HALT, left as NOP
                if (dst_f == 3'b110 && src_f != 3'b110)      op_class = OP_LD_HL_R;
                else if (src_f == 3'b110 && dst_f != 3'b110) op_class = OP_LD_R_HL;
                else if (src_f != 3'b110)                    op_class = OP_LD_RR;
            end
            2'b10: op_class = (src_f == 3'b110) ? OP_ALU_HL : OP_ALU_R;
            default: if (src_f == 3'b110) op_class = OP_ALU_N;
        endcase
    end

    always_comb begin
        case (op_class)
            OP_LD_R_HL, OP_LD_HL_R, OP_LD_R_N,
            OP_ALU_HL, OP_ALU_N:  m_count = `M_CNT_W'(2);
            OP_LD_RR_NN:          m_count = `M_CNT_W'(3);
            default:              m_count = `M_CNT_W'(1);
        endcase
    end

    // One step per M-cycle; the final M-cycle never touches memory
    always_comb begin
        step = '0;  // PC, SBUS, ADD and B as idle values
        case (op_class)
            OP_LD_RR: begin
                step.reg_rd_en   = 1'b1;
                step.reg_rd_addr = reg_sel_e'(src_f);
                step.reg_wr      = 1'b1;
                step.reg_wr_addr = reg_sel_e'(dst_f);
            end
            OP_LD_HL_R: if (first_m) begin
                step.mem_wr      = 1'b1;
                step.addr_sel    = HL;
                step.reg_rd_en   = 1'b1;
                step.reg_rd_addr = reg_sel_e'(src_f);  // Drives the write data
            end
            OP_LD_R_HL, OP_LD_R_N: begin
                if (first_m) begin
                    step.mem_rd   = 1'b1;
                    step.addr_sel = (op_class == OP_LD_R_HL) ? HL : PC;
                end else begin
                    step.reg_wr      = 1'b1;
                    step.reg_wr_addr = reg_sel_e'(dst_f);
                    step.src_sel     = MEM;
                end
            end
            OP_ALU_R, OP_ALU_HL, OP_ALU_N: begin
                if (op_class != OP_ALU_R && first_m) begin
                    step.mem_rd   = 1'b1;
                    step.addr_sel = (op_class == OP_ALU_HL) ? HL : PC;
                end else begin
                    step.alu_go      = 1'b1;
                    step.alu_op      = alu_op_e'(dst_f);
                    step.alu_mem_src = (op_class != OP_ALU_R);
                    step.reg_rd_en   = (op_class == OP_ALU_R);
                    step.reg_rd_addr = reg_sel_e'(src_f);
                    step.reg_wr      = 1'b1;
                    step.reg_wr_addr = A;  // Result back to the accumulator
                    step.src_sel     = ALU;
                end
            end
            OP_INC_R, OP_DEC_R: begin
                step.alu_go      = 1'b1;
                step.alu_op      = (op_class == OP_INC_R) ? ADD : SUB;
                step.alu_incdec  = 1'b1;
                step.reg_rd_en   = 1'b1;
                step.reg_rd_addr = reg_sel_e'(dst_f);
                step.reg_wr      = 1'b1;
                step.reg_wr_addr = reg_sel_e'(dst_f);
                step.src_sel     = ALU;
            end
            OP_LD_RR_NN: begin
                // Low byte lands in M2, high byte in M3
                step.mem_rd      = (cycle.m_cycle != `M_CNT_W'(2));
                step.reg_wr      = !first_m;
                step.reg_wr_addr = (cycle.m_cycle == `M_CNT_W'(1)) ? pair_lo : pair_hi;
                step.src_sel     = MEM;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/strobe_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module strobe_gen import cpu_decode_pkg::*; (
    input  cycle_t    cycle,
    input  step_t     step,
    output reg_ctrl_t reg_ctrl,
    output alu_ctrl_t alu_ctrl,
    output mem_ctrl_t mem_ctrl,
    output logic      pc_wr_en
);

    logic      in_t3;
    logic      in_t4;
    logic      rd_req;
    addr_src_e addr;

    assign in_t3 = (cycle.t_phase == T3);
    assign in_t4 = (cycle.t_phase == T4);

    // Final M-cycle always carries the next opcode fetch
    assign rd_req = step.mem_rd | cycle.last_m;
    assign addr   = cycle.last_m ? PC : step.addr_sel;

    // Memory bus, strobes in T3 only
    assign mem_ctrl.rd       = rd_req & in_t3;
    assign mem_ctrl.wr       = step.mem_wr & in_t3;
    assign mem_ctrl.addr_sel = addr;

    // Step PC once the byte at PC has been taken
    assign pc_wr_en = in_t4 & rd_req & (addr == PC);

    assign reg_ctrl.rd_en   = step.reg_rd_en;
    assign reg_ctrl.rd_addr = step.reg_rd_addr;
    assign reg_ctrl.wr_en   = step.reg_wr & (in_t3 | in_t4);  // Write back in T3/T4
    assign reg_ctrl.wr_addr = step.reg_wr_addr;
    assign reg_ctrl.src_sel = step.src_sel;

    // ALU runs T2 through T4
    assign alu_ctrl.start   = step.alu_go & (cycle.t_phase != T1);
    assign alu_ctrl.op      = step.alu_op;
    assign alu_ctrl.mem_src = step.alu_mem_src;
    assign alu_ctrl.incdec  = step.alu_incdec;

endmodule

`default_nettype wire

// ==== design/decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decode_top import cpu_decode_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [`DATA_W-1:0] data_bus_in,
    output reg_ctrl_t          reg_ctrl,
    output alu_ctrl_t          alu_ctrl,
    output mem_ctrl_t          mem_ctrl,
    output logic               pc_wr_en,
    output cycle_t             cycle
);

    logic [`DATA_W-1:0]  opcode;
    logic                end_of_instr;
    logic [`M_CNT_W-1:0] m_count;
    step_t               step;

    ir_fetch u_ir_fetch (
        .clk          (clk),
        .rst          (rst),
        .data_bus_in  (data_bus_in),
        .end_of_instr (end_of_instr),
        .opcode       (opcode)
    );

    cycle_timer u_cycle_timer (
        .clk          (clk),
        .rst          (rst),
        .m_count      (m_count),
        .cycle        (cycle),
        .end_of_instr (end_of_instr)
    );

    // Decode and strobe paths are combinational from the two registers
    op_decoder u_op_decoder (
        .opcode  (opcode),
        .cycle   (cycle),
        .m_count (m_count),
        .step    (step)
    );

    strobe_gen u_strobe_gen (
        .cycle    (cycle),
        .step     (step),
        .reg_ctrl (reg_ctrl),
        .alu_ctrl (alu_ctrl),
        .mem_ctrl (mem_ctrl),
        .pc_wr_en (pc_wr_en)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // Reset held for 10 cycles, released just after a rising edge
    initial begin
        rst = 1'b0;
        repeat (10) @(posedge clk);
        #2 rst = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/tb_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module tb_decode import cpu_decode_pkg::*; ();

    localparam int NUM_OPS        = 200;
    localparam int TIMEOUT_CYCLES = 10 + NUM_OPS * 12 + 50;

    logic               clk;
    logic               rst;
    logic [`DATA_W-1:0] data_bus_in;
    reg_ctrl_t          reg_ctrl;
    alu_ctrl_t          alu_ctrl;
    mem_ctrl_t          mem_ctrl;
    logic               pc_wr_en;
    cycle_t             cycle;
    logic [4:0]         strobes;
    logic [31:0]        lfsr_state = 32'h7922_7c6e;
    int                 n_ops;
    int                 cycle_count = 0;

    // Reference sequencer
    logic [1:0]         ref_t;
    logic [1:0]         ref_m;
    logic [7:0]         ref_op;
    op_class_e          ref_class;
    logic [1:0]         ref_mc;
    logic               ref_final;
    reg_sel_e           src_r;
    reg_sel_e           dst_r;

    // Untimed intent of the current M-cycle and the timed expectations
    logic               want_rd, want_wr, want_wreg, want_alu;
    logic               exp_rd, exp_wr, exp_wr_en, exp_alu, exp_pc;
    logic               exp_rd_en, exp_mem_src, exp_incdec;
    addr_src_e          exp_addr;
    reg_sel_e           exp_rd_addr;
    reg_sel_e           exp_wr_addr;
    dbus_src_e          exp_src;
    alu_op_e            exp_op;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    decode_top uut (
        .clk         (clk),
        .rst         (rst),
        .data_bus_in (data_bus_in),
        .reg_ctrl    (reg_ctrl),
        .alu_ctrl    (alu_ctrl),
        .mem_ctrl    (mem_ctrl),
        .pc_wr_en    (pc_wr_en),
        .cycle       (cycle)
    );

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            else
                lfsr_state = lfsr_state >> 1;
            val = {val[6:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // Kept groups with random fields, plus NOPs and unsupported codes
    function automatic logic [7:0] pick_opcode();
        logic [3:0] grp;
        logic [2:0] r;
        logic [2:0] f;
        grp = 4'(rand_bits(4));
        r   = 3'(rand_bits(3));
        f   = 3'(rand_bits(3));
        case (grp)
            4'd0:        return `NOP_OPCODE;
            4'd1:        return {2'b00, r, 3'b111};  // Rotates and misc are unsupported
            4'd2, 4'd3:  return {2'b01, r, f};
            4'd4:        return {2'b01, r, 3'b110};
            4'd5:        return {2'b01, 3'b110, f};
            4'd6:        return {2'b00, r, 3'b110};
            4'd7, 4'd8:  return {2'b10, r, f};
            4'd9:        return {2'b11, r, 3'b110};
            4'd10:       return {2'b00, r, 3'b100};
            4'd11:       return {2'b00, r, 3'b101};
            4'd12, 4'd13: return {2'b00, r[1:0], 4'b0001};  // Pair 3 is SP and unsupported
            4'd14:       return {2'b10, r, 3'b110};
            default:     return {2'b11, r, f};
        endcase
    endfunction

    // Group of an opcode from the SM83 opcode map
    function automatic op_class_e classify(input logic [7:0] op);
        logic [2:0] y;
        logic [2:0] z;
        y = op[5:3];
        z = op[2:0];
        case (op[7:6])
            2'b01: begin
                if (op == 8'h76) return OP_NOP;  // HALT
                if (y == 3'd6) return OP_LD_HL_R;
                if (z == 3'd6) return OP_LD_R_HL;
                return OP_LD_RR;
            end
            2'b10: return (z == 3'd6) ? OP_ALU_HL : OP_ALU_R;
            2'b11: return (z == 3'd6) ? OP_ALU_N : OP_NOP;
            default: begin
                if (op[3:0] == 4'h1 && op[5:4] != 2'b11) return OP_LD_RR_NN;
                if (y == 3'd6) return OP_NOP;
                if (z == 3'd4) return OP_INC_R;
                if (z == 3'd5) return OP_DEC_R;
                if (z == 3'd6) return OP_LD_R_N;
                return OP_NOP;
            end
        endcase
    endfunction

    function automatic logic [1:0] m_cycles(input op_class_e c);
        case (c)
            OP_LD_R_HL, OP_LD_HL_R, OP_LD_R_N, OP_ALU_HL, OP_ALU_N: return 2'd2;
            OP_LD_RR_NN: return 2'd3;
            default:     return 2'd1;
        endcase
    endfunction

    task automatic fail_value(
        input string       sig,
        input logic [15:0] expected,
        input logic [15:0] actual
    );
        $display("Fail at %0t ns: %s expected %0h, got %0h", $time, sig, expected, actual);
        $display("Errors found");
        $fatal(1, "mismatch on %s", sig);
    endtask

    // Opcode latched at the end of the final T4
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            ref_t  <= 2'd0;
            ref_m  <= 2'd0;
            ref_op <= `NOP_OPCODE;
        end else if (ref_t == 2'd3) begin
            ref_t <= 2'd0;
            if (ref_final) begin
                ref_m  <= 2'd0;
                ref_op <= data_bus_in;
            end else begin
                ref_m <= ref_m + 2'd1;
            end
        end else begin
            ref_t <= ref_t + 2'd1;
        end
    end

    assign ref_class = classify(ref_op);
    assign ref_mc    = m_cycles(ref_class);
    assign ref_final = (ref_m == ref_mc - 2'd1);
    assign src_r     = reg_sel_e'(ref_op[2:0]);
    assign dst_r     = reg_sel_e'(ref_op[5:3]);
    assign strobes   = {mem_ctrl.rd, mem_ctrl.wr, reg_ctrl.wr_en, alu_ctrl.start, pc_wr_en};

    always_comb begin
        want_rd     = 1'b0;
        want_wr     = 1'b0;
        want_wreg   = 1'b0;
        want_alu    = 1'b0;
        exp_addr    = PC;
        exp_rd_en   = 1'b0;
        exp_rd_addr = src_r;
        exp_wr_addr = dst_r;
        exp_src     = SBUS;
        exp_op      = alu_op_e'(ref_op[5:3]);
        exp_mem_src = 1'b0;
        exp_incdec  = 1'b0;
        case (ref_class)
            OP_LD_RR: begin
                exp_rd_en = 1'b1;
                want_wreg = 1'b1;
            end
            OP_LD_HL_R: if (ref_m == 2'd0) begin
                want_wr   = 1'b1;
                exp_addr  = HL;
                exp_rd_en = 1'b1;  // Source register feeds the write
            end
            OP_LD_R_HL, OP_LD_R_N: begin
                if (ref_m == 2'd0) begin
                    want_rd  = 1'b1;
                    exp_addr = (ref_class == OP_LD_R_HL) ? HL : PC;
                end else begin
                    want_wreg = 1'b1;
                    exp_src   = MEM;
                end
            end
            OP_ALU_R, OP_ALU_HL, OP_ALU_N: begin
                if (ref_class != OP_ALU_R && ref_m == 2'd0) begin
                    want_rd  = 1'b1;
                    exp_addr = (ref_class == OP_ALU_HL) ? HL : PC;
                end else begin
                    want_alu    = 1'b1;
                    want_wreg   = 1'b1;
                    exp_wr_addr = A;
                    exp_src     = ALU;
                    exp_mem_src = (ref_class != OP_ALU_R);
                    exp_rd_en   = (ref_class == OP_ALU_R);
                end
            end
            OP_INC_R, OP_DEC_R: begin
                want_alu    = 1'b1;
                want_wreg   = 1'b1;
                exp_op      = (ref_class == OP_INC_R) ? ADD : SUB;
                exp_incdec  = 1'b1;
                exp_rd_en   = 1'b1;
                exp_rd_addr = dst_r;
                exp_src     = ALU;
            end
            OP_LD_RR_NN: begin
                want_rd     = (ref_m != 2'd2);
                want_wreg   = (ref_m != 2'd0);
                exp_wr_addr = reg_sel_e'({ref_op[5:4], ref_m == 2'd1});  // Low byte first
                exp_src     = MEM;
            end
            default: ;
        endcase
        if (ref_final) begin
            want_rd  = 1'b1;  // Next opcode fetch
            exp_addr = PC;
        end
        exp_rd    = want_rd && ref_t == 2'd2;
        exp_wr    = want_wr && ref_t == 2'd2;
        exp_wr_en = want_wreg && ref_t[1];
        exp_alu   = want_alu && ref_t != 2'd0;
        exp_pc    = want_rd && exp_addr == PC && ref_t == 2'd3;
    end

    // Checks sample on the falling edge where everything has settled
    chk_reset: assert property (@(negedge clk) !rst |-> strobes == 5'b0)
        else fail_value("strobes in reset", 16'h0, 16'(strobes));
    chk_cycle: assert property (@(negedge clk) disable iff (!rst)
            cycle == {ref_m, ref_t, ref_final})
        else fail_value("cycle", 16'({ref_m, ref_t, ref_final}), 16'(cycle));
    chk_rd: assert property (@(negedge clk) disable iff (!rst) mem_ctrl.rd == exp_rd)
        else fail_value("mem_ctrl.rd", 16'(exp_rd), 16'(mem_ctrl.rd));
    chk_wr: assert property (@(negedge clk) disable iff (!rst) mem_ctrl.wr == exp_wr)
        else fail_value("mem_ctrl.wr", 16'(exp_wr), 16'(mem_ctrl.wr));
    chk_addr: assert property (@(negedge clk) disable iff (!rst)
            (exp_rd || exp_wr) |-> mem_ctrl.addr_sel == exp_addr)
        else fail_value("mem_ctrl.addr_sel", 16'(exp_addr), 16'(mem_ctrl.addr_sel));
    chk_pc: assert property (@(negedge clk) disable iff (!rst) pc_wr_en == exp_pc)
        else fail_value("pc_wr_en", 16'(exp_pc), 16'(pc_wr_en));
    chk_wr_en: assert property (@(negedge clk) disable iff (!rst) reg_ctrl.wr_en == exp_wr_en)
        else fail_value("reg_ctrl.wr_en", 16'(exp_wr_en), 16'(reg_ctrl.wr_en));
    chk_wr_dst: assert property (@(negedge clk) disable iff (!rst)
            exp_wr_en |-> {reg_ctrl.wr_addr, reg_ctrl.src_sel} == {exp_wr_addr, exp_src})
        else fail_value("reg_ctrl.wr_addr,src_sel", 16'({exp_wr_addr, exp_src}),
                        16'({reg_ctrl.wr_addr, reg_ctrl.src_sel}));
    chk_rd_en: assert property (@(negedge clk) disable iff (!rst) reg_ctrl.rd_en == exp_rd_en)
        else fail_value("reg_ctrl.rd_en", 16'(exp_rd_en), 16'(reg_ctrl.rd_en));
    chk_rd_addr: assert property (@(negedge clk) disable iff (!rst)
            exp_rd_en |-> reg_ctrl.rd_addr == exp_rd_addr)
        else fail_value("reg_ctrl.rd_addr", 16'(exp_rd_addr), 16'(reg_ctrl.rd_addr));
    chk_alu: assert property (@(negedge clk) disable iff (!rst) alu_ctrl.start == exp_alu)
        else fail_value("alu_ctrl.start", 16'(exp_alu), 16'(alu_ctrl.start));
    chk_alu_op: assert property (@(negedge clk) disable iff (!rst)
            exp_alu |-> {alu_ctrl.op, alu_ctrl.mem_src, alu_ctrl.incdec}
                        == {exp_op, exp_mem_src, exp_incdec})
        else fail_value("alu_ctrl.op,mem_src,incdec", 16'({exp_op, exp_mem_src, exp_incdec}),
                        16'({alu_ctrl.op, alu_ctrl.mem_src, alu_ctrl.incdec}));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    initial begin
        data_bus_in = `NOP_OPCODE;
        n_ops       = 0;
        wait (rst === 1'b1);
        // Bus holds a byte from T3 until the M-cycle ends
        while (n_ops <= NUM_OPS) begin
            @(posedge clk);
            #2;
            if (ref_t == 2'd2 && ref_final) begin
                n_ops++;
                if (n_ops <= NUM_OPS)
                    data_bus_in = pick_opcode();
            end else if (ref_t == 2'd2) begin
                data_bus_in = rand_bits(8);  // Operand byte
            end
        end
        repeat (2) @(posedge clk);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/cpu_decode_pkg.sv
design/ir_fetch.sv
design/cycle_timer.sv
design/op_decoder.sv
design/strobe_gen.sv
design/decode_top.sv
verif/tb_clk_gen.sv
verif/tb_decode.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_decode \
    -Mdir obj_dir -o tb_decode
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_decode
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
